/* list.f */
vrf_pkg.sv
vrf_bank.sv
vrf.sv
vec_fu.sv
vrf_top.sv
vrf_props.sv
tb_vrf_top.sv

/* tb_vrf_top.sv */
// Vector register file testbench
// Table of LSU, slide and VFU requests checked against a register model

module tb_vrf_top;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic                lsu_we, lsu_re, sld_we, sld_re, vfu_valid;
    logic                lsu_wv, lsu_rv, sld_wv, sld_rv, done;
    vrf_pkg::vfu_op_e    op;
    vrf_pkg::vreg_addr_t lsu_waddr, lsu_raddr, sld_waddr, sld_raddr, vd, vs1, vs2;
    vrf_pkg::vreg_data_t lsu_wdata, sld_wdata;
    vrf_pkg::vreg_be_t   lsu_wbe, sld_wbe;
  } row_t;

  logic                clk_i;
  logic                arst_n_i;
  logic                vfu_valid_i;
  vrf_pkg::vfu_op_e    vfu_op_i;
  vrf_pkg::vreg_addr_t vfu_vd_i, vfu_vs1_i, vfu_vs2_i;
  logic                vfu_done_o;
  logic                lsu_we_i, lsu_wvalid_o, lsu_re_i, lsu_rvalid_o;
  vrf_pkg::vreg_addr_t lsu_waddr_i, lsu_raddr_i;
  vrf_pkg::vreg_data_t lsu_wdata_i, lsu_rdata_o;
  vrf_pkg::vreg_be_t   lsu_wbe_i;
  logic                sld_we_i, sld_wvalid_o, sld_re_i, sld_rvalid_o;
  vrf_pkg::vreg_addr_t sld_waddr_i, sld_raddr_i;
  vrf_pkg::vreg_data_t sld_wdata_i, sld_rdata_o;
  vrf_pkg::vreg_be_t   sld_wbe_i;

  row_t                rows[$];
  row_t                cur;
  vrf_pkg::vreg_data_t model [vrf_pkg::NrVregs];
  logic                pend_valid;
  vrf_pkg::vreg_addr_t pend_vd;
  vrf_pkg::vreg_data_t pend_data;
  int unsigned         cycle_cnt = 0;

  vrf_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > rows.size() * 4 + 50) begin
      $display("timeout: the test table did not finish");
      $display("Test FAILED");
      $fatal(1, "Run stopped by timeout");
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_data(input string name, input vrf_pkg::vreg_data_t exp,
                            input vrf_pkg::vreg_data_t act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
      $display("Test FAILED");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
      $display("Test FAILED");
      $fatal(1, "Bit mismatch");
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic void model_write(vrf_pkg::vreg_addr_t a, vrf_pkg::vreg_data_t d,
                                      vrf_pkg::vreg_be_t be);
    for (int b = 0; b < 8; b++) begin
      if (be[b]) model[a][b*8 +: 8] = d[b*8 +: 8];
    end
  endfunction

  // Two 32-bit lanes, each sum wraps on its own
  function automatic vrf_pkg::vreg_data_t vfu_expect(vrf_pkg::vfu_op_e op,
      vrf_pkg::vreg_data_t s1, vrf_pkg::vreg_data_t s2, vrf_pkg::vreg_data_t d);
    logic [31:0]         lane;
    vrf_pkg::vreg_data_t res;
    for (int l = 0; l < 2; l++) begin
      case (op)
        vrf_pkg::OP_ADD: lane = s1[l*32 +: 32] + s2[l*32 +: 32];
        vrf_pkg::OP_SUB: lane = s1[l*32 +: 32] - s2[l*32 +: 32];
        vrf_pkg::OP_XOR: lane = s1[l*32 +: 32] ^ s2[l*32 +: 32];
        default:         lane = d[l*32 +: 32] + s1[l*32 +: 32] + s2[l*32 +: 32];
      endcase
      res[l*32 +: 32] = lane;
    end
    return res;
  endfunction

  // Operand reads see the state before this row's writes land
  task automatic update_model(input row_t r);
    vrf_pkg::vreg_data_t res;
    res = vfu_expect(r.op, model[r.vs1], model[r.vs2], model[r.vd]);
    if (pend_valid) model_write(pend_vd, pend_data, '1);
    if (r.lsu_wv) model_write(r.lsu_waddr, r.lsu_wdata, r.lsu_wbe);
    if (r.sld_wv) model_write(r.sld_waddr, r.sld_wdata, r.sld_wbe);
    pend_valid = r.vfu_valid;
    pend_vd    = r.vd;
    pend_data  = res;
  endtask

  ////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////

  function automatic vrf_pkg::vreg_data_t rnd_word();
    return {$urandom, $urandom};
  endfunction

  function automatic void lsu_write(vrf_pkg::vreg_addr_t a, vrf_pkg::vreg_data_t d,
                                    vrf_pkg::vreg_be_t be, logic wv);
    cur.lsu_we    = 1'b1;
    cur.lsu_waddr = a;
    cur.lsu_wdata = d;
    cur.lsu_wbe   = be;
    cur.lsu_wv    = wv;
  endfunction

  function automatic void sld_write(vrf_pkg::vreg_addr_t a, vrf_pkg::vreg_data_t d,
                                    vrf_pkg::vreg_be_t be, logic wv);
    cur.sld_we    = 1'b1;
    cur.sld_waddr = a;
    cur.sld_wdata = d;
    cur.sld_wbe   = be;
    cur.sld_wv    = wv;
  endfunction

  function automatic void lsu_read(vrf_pkg::vreg_addr_t a, logic rv);
    cur.lsu_re    = 1'b1;
    cur.lsu_raddr = a;
    cur.lsu_rv    = rv;
  endfunction

  function automatic void sld_read(vrf_pkg::vreg_addr_t a, logic rv);
    cur.sld_re    = 1'b1;
    cur.sld_raddr = a;
    cur.sld_rv    = rv;
  endfunction

  function automatic void vfu_cmd(vrf_pkg::vfu_op_e op, vrf_pkg::vreg_addr_t vd,
                                  vrf_pkg::vreg_addr_t vs1, vrf_pkg::vreg_addr_t vs2);
    cur.vfu_valid = 1'b1;
    cur.op        = op;
    cur.vd        = vd;
    cur.vs1       = vs1;
    cur.vs2       = vs2;
  endfunction

  function automatic void push_row(logic done);
    cur.done = done;
    rows.push_back(cur);
    cur = '0;
  endfunction

  task automatic build_table();
    vrf_pkg::vreg_data_t d;
    cur = '0;
    // Everything reads zero out of reset
    for (int i = 0; i < 8; i++) begin
      lsu_read(4'(2*i), 1'b1);
      sld_read(4'(2*i+1), 1'b1);
      push_row(1'b0);
    end
    // Fill: LSU on bank 0, slide on bank 1, same cycle
    for (int i = 0; i < 8; i++) begin
      lsu_write(4'(2*i), rnd_word(), 8'hFF, 1'b1);
      sld_write(4'(2*i+1), rnd_word(), 8'hFF, 1'b1);
      push_row(1'b0);
    end
    lsu_write(4'd2, rnd_word(), 8'h0F, 1'b1);
    sld_write(4'd3, rnd_word(), 8'hA5, 1'b1);
    push_row(1'b0);
    lsu_read(4'd2, 1'b1);
    sld_read(4'd3, 1'b1);
    push_row(1'b0);
    // Same bank, LSU beats slide
    lsu_write(4'd4, rnd_word(), 8'hFF, 1'b1);
    sld_write(4'd6, rnd_word(), 8'hFF, 1'b0);
    push_row(1'b0);
    lsu_read(4'd4, 1'b1);
    sld_read(4'd6, 1'b1);
    push_row(1'b0);
    // Slide loses bank 1 port 1 to VFU vs1
    vfu_cmd(vrf_pkg::OP_ADD, 4'd9, 4'd3, 4'd0);
    sld_read(4'd5, 1'b0);
    lsu_read(4'd7, 1'b1);
    push_row(1'b0);
    // LSU loses bank 0 port 2 to the OP_ACC vd read
    vfu_cmd(vrf_pkg::OP_ACC, 4'd10, 4'd1, 4'd2);
    lsu_read(4'd12, 1'b0);
    push_row(1'b1);
    lsu_read(4'd9, 1'b1);
    push_row(1'b1);
    lsu_read(4'd10, 1'b1);
    push_row(1'b0);
    // Every opcode on random operands
    for (int i = 0; i < 4; i++) begin
      vfu_cmd(vrf_pkg::vfu_op_e'(i), 4'(12+i), 4'(i), 4'(i+4));
      push_row(1'b0);
      push_row(1'b1);
      lsu_read(4'(12+i), 1'b1);
      push_row(1'b0);
    end
    // Back to back commands
    vfu_cmd(vrf_pkg::OP_ADD, 4'd12, 4'd1, 4'd2);
    push_row(1'b0);
    vfu_cmd(vrf_pkg::OP_XOR, 4'd13, 4'd5, 4'd6);
    push_row(1'b1);
    push_row(1'b1);
    lsu_read(4'd12, 1'b1);
    sld_read(4'd13, 1'b1);
    push_row(1'b0);
    // VFU writeback beats the LSU, which retries
    d = rnd_word();
    vfu_cmd(vrf_pkg::OP_SUB, 4'd14, 4'd1, 4'd3);
    push_row(1'b0);
    lsu_write(4'd0, d, 8'hFF, 1'b0);
    push_row(1'b1);
    lsu_write(4'd0, d, 8'hFF, 1'b1);
    push_row(1'b0);
    lsu_read(4'd14, 1'b1);
    sld_read(4'd0, 1'b1);
    push_row(1'b0);
  endtask

  ////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////

  task automatic drive_row(input row_t r);
    vfu_valid_i <= r.vfu_valid;
    vfu_op_i    <= r.op;
    vfu_vd_i    <= r.vd;
    vfu_vs1_i   <= r.vs1;
    vfu_vs2_i   <= r.vs2;
    lsu_we_i    <= r.lsu_we;
    lsu_waddr_i <= r.lsu_waddr;
    lsu_wdata_i <= r.lsu_wdata;
    lsu_wbe_i   <= r.lsu_wbe;
    lsu_re_i    <= r.lsu_re;
    lsu_raddr_i <= r.lsu_raddr;
    sld_we_i    <= r.sld_we;
    sld_waddr_i <= r.sld_waddr;
    sld_wdata_i <= r.sld_wdata;
    sld_wbe_i   <= r.sld_wbe;
    sld_re_i    <= r.sld_re;
    sld_raddr_i <= r.sld_raddr;
  endtask

  // Losing or idle reads return zero data
  task automatic check_row(input row_t r);
    check_bit("lsu_wvalid_o", r.lsu_wv, lsu_wvalid_o);
    check_bit("sld_wvalid_o", r.sld_wv, sld_wvalid_o);
    check_bit("lsu_rvalid_o", r.lsu_rv, lsu_rvalid_o);
    check_bit("sld_rvalid_o", r.sld_rv, sld_rvalid_o);
    check_bit("vfu_done_o", r.done, vfu_done_o);
    check_data("lsu_rdata_o", r.lsu_rv ? model[r.lsu_raddr] : '0, lsu_rdata_o);
    check_data("sld_rdata_o", r.sld_rv ? model[r.sld_raddr] : '0, sld_rdata_o);
  endtask

  initial begin
    void'($urandom(18));
    arst_n_i   = 1'b0;
    pend_valid = 1'b0;
    drive_row('0);
    foreach (model[i]) model[i] = '0;
    build_table();
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    foreach (rows[i]) begin
      @(posedge clk_i);
      drive_row(rows[i]);
      @(negedge clk_i);
      check_row(rows[i]);
      update_model(rows[i]);
    end
    @(posedge clk_i);
    drive_row('0);
    @(posedge clk_i);
    if (dut.i_vrf.i_vrf_props.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Write grant assertions failed in the register file");
      $display("Test FAILED");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

/* vrf_props.sv */
// Vector register file write grant checks
// Bound into the register file, checks the write port mapping

module vrf_props (
  input logic                                            clk_i,
  input logic                                            arst_n_i,
  input vrf_pkg::vreg_addr_t [vrf_pkg::NrWritePorts-1:0] waddr_i,
  input logic                [vrf_pkg::NrWritePorts-1:0] we_i,
  input logic                [vrf_pkg::NrWritePorts-1:0] wvalid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  // Granted requesters, split by the bank they target
  logic [vrf_pkg::NrBanks-1:0][vrf_pkg::NrWritePorts-1:0] bank_grant;

  always_comb begin
    for (int b = 0; b < vrf_pkg::NrBanks; b++) begin
      for (int w = 0; w < vrf_pkg::NrWritePorts; w++) begin
        bank_grant[b][w] = wvalid_i[w] && (waddr_i[w].bank == 1'(b));
      end
    end
  end

  ////////////////////////////////////////
  // Write grants
  ////////////////////////////////////////

  a_wvalid_needs_we: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (wvalid_i & ~we_i) == '0)
    else begin
      $error("write valid raised without write enable");
      fail_count++;
    end

  a_one_grant_per_bank: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(bank_grant[0]) && $onehot0(bank_grant[1]))
    else begin
      $error("more than one write granted in a bank");
      fail_count++;
    end

  a_vfu_write_granted: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    we_i[vrf_pkg::VFU_VD_WD] |-> wvalid_i[vrf_pkg::VFU_VD_WD])
    else begin
      $error("VFU write not granted");
      fail_count++;
    end

endmodule

bind vrf vrf_props i_vrf_props (
  .clk_i   (clk_i   ),
  .arst_n_i(arst_n_i),
  .waddr_i (waddr_i ),
  .we_i    (we_i    ),
  .wvalid_i(wvalid_o)
);

/* vrf_top.sv */
// Vector register file top level
// VFU plus register file, with the LSU and slide ports brought out

module vrf_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // VFU command
  input  logic                vfu_valid_i,
  input  vrf_pkg::vfu_op_e    vfu_op_i,
  input  vrf_pkg::vreg_addr_t vfu_vd_i,
  input  vrf_pkg::vreg_addr_t vfu_vs1_i,
  input  vrf_pkg::vreg_addr_t vfu_vs2_i,
  output logic                vfu_done_o,
  // LSU
  input  logic                lsu_we_i,
  input  vrf_pkg::vreg_addr_t lsu_waddr_i,
  input  vrf_pkg::vreg_data_t lsu_wdata_i,
  input  vrf_pkg::vreg_be_t   lsu_wbe_i,
  output logic                lsu_wvalid_o,
  input  logic                lsu_re_i,
  input  vrf_pkg::vreg_addr_t lsu_raddr_i,
  output vrf_pkg::vreg_data_t lsu_rdata_o,
  output logic                lsu_rvalid_o,
  // Slide unit
  input  logic                sld_we_i,
  input  vrf_pkg::vreg_addr_t sld_waddr_i,
  input  vrf_pkg::vreg_data_t sld_wdata_i,
  input  vrf_pkg::vreg_be_t   sld_wbe_i,
  output logic                sld_wvalid_o,
  input  logic                sld_re_i,
  input  vrf_pkg::vreg_addr_t sld_raddr_i,
  output vrf_pkg::vreg_data_t sld_rdata_o,
  output logic                sld_rvalid_o
);

  // Requester arrays, indexed by the port enums
  vrf_pkg::vreg_addr_t [vrf_pkg::NrWritePorts-1:0] waddr;
  vrf_pkg::vreg_data_t [vrf_pkg::NrWritePorts-1:0] wdata;
  logic                [vrf_pkg::NrWritePorts-1:0] we;
  vrf_pkg::vreg_be_t   [vrf_pkg::NrWritePorts-1:0] wbe;
  logic                [vrf_pkg::NrWritePorts-1:0] wvalid;
  vrf_pkg::vreg_addr_t [vrf_pkg::NrReadPorts-1:0]  raddr;
  logic                [vrf_pkg::NrReadPorts-1:0]  re;
  vrf_pkg::vreg_data_t [vrf_pkg::NrReadPorts-1:0]  rdata;
  logic                [vrf_pkg::NrReadPorts-1:0]  rvalid;

  ////////////////////////////////////////
  // Requester packing
  ////////////////////////////////////////

  assign wbe[vrf_pkg::VFU_VD_WD]   = '1;
  assign we[vrf_pkg::VLSU_VD_WD]   = lsu_we_i;
  assign waddr[vrf_pkg::VLSU_VD_WD] = lsu_waddr_i;
  assign wdata[vrf_pkg::VLSU_VD_WD] = lsu_wdata_i;
  assign wbe[vrf_pkg::VLSU_VD_WD]  = lsu_wbe_i;
  assign we[vrf_pkg::VSLDU_VD_WD]  = sld_we_i;
  assign waddr[vrf_pkg::VSLDU_VD_WD] = sld_waddr_i;
  assign wdata[vrf_pkg::VSLDU_VD_WD] = sld_wdata_i;
  assign wbe[vrf_pkg::VSLDU_VD_WD] = sld_wbe_i;
  assign lsu_wvalid_o = wvalid[vrf_pkg::VLSU_VD_WD];
  assign sld_wvalid_o = wvalid[vrf_pkg::VSLDU_VD_WD];

  assign re[vrf_pkg::VLSU_VD_RD]      = lsu_re_i;
  assign raddr[vrf_pkg::VLSU_VD_RD]   = lsu_raddr_i;
  assign re[vrf_pkg::VSLDU_VS2_RD]    = sld_re_i;
  assign raddr[vrf_pkg::VSLDU_VS2_RD] = sld_raddr_i;
  assign lsu_rdata_o  = rdata[vrf_pkg::VLSU_VD_RD];
  assign lsu_rvalid_o = rvalid[vrf_pkg::VLSU_VD_RD];
  assign sld_rdata_o  = rdata[vrf_pkg::VSLDU_VS2_RD];
  assign sld_rvalid_o = rvalid[vrf_pkg::VSLDU_VS2_RD];

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  vec_fu i_vec_fu (
    .clk_i     (clk_i                         ),
    .arst_n_i  (arst_n_i                      ),
    .valid_i   (vfu_valid_i                   ),
    .op_i      (vfu_op_i                      ),
    .vd_i      (vfu_vd_i                      ),
    .vs1_i     (vfu_vs1_i                     ),
    .vs2_i     (vfu_vs2_i                     ),
    .vs1_re_o  (re[vrf_pkg::VFU_VS1_RD]       ),
    .vs2_re_o  (re[vrf_pkg::VFU_VS2_RD]       ),
    .vd_re_o   (re[vrf_pkg::VFU_VD_RD]        ),
    .vs1_addr_o(raddr[vrf_pkg::VFU_VS1_RD]    ),
    .vs2_addr_o(raddr[vrf_pkg::VFU_VS2_RD]    ),
    .vd_raddr_o(raddr[vrf_pkg::VFU_VD_RD]     ),
    .vs1_data_i(rdata[vrf_pkg::VFU_VS1_RD]    ),
    .vs2_data_i(rdata[vrf_pkg::VFU_VS2_RD]    ),
    .vd_data_i (rdata[vrf_pkg::VFU_VD_RD]     ),
    .we_o      (we[vrf_pkg::VFU_VD_WD]        ),
    .waddr_o   (waddr[vrf_pkg::VFU_VD_WD]     ),
    .wdata_o   (wdata[vrf_pkg::VFU_VD_WD]     ),
    .done_o    (vfu_done_o                    )
  );

  vrf i_vrf (
    .clk_i   (clk_i   ),
    .arst_n_i(arst_n_i),
    .waddr_i (waddr   ),
    .wdata_i (wdata   ),
    .we_i    (we      ),
    .wbe_i   (wbe     ),
    .wvalid_o(wvalid  ),
    .raddr_i (raddr   ),
    .re_i    (re      ),
    .rdata_o (rdata   ),
    .rvalid_o(rvalid  )
  );

endmodule

/* vec_fu.sv */
// Vector function unit
// Two-stage pipeline: operand read and lane-wise compute, then writeback

module vec_fu (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Command
  input  logic                valid_i,
  input  vrf_pkg::vfu_op_e    op_i,
  input  vrf_pkg::vreg_addr_t vd_i,
  input  vrf_pkg::vreg_addr_t vs1_i,
  input  vrf_pkg::vreg_addr_t vs2_i,
  // Operand reads
  output logic                vs1_re_o,
  output logic                vs2_re_o,
  output logic                vd_re_o,
  output vrf_pkg::vreg_addr_t vs1_addr_o,
  output vrf_pkg::vreg_addr_t vs2_addr_o,
  output vrf_pkg::vreg_addr_t vd_raddr_o,
  input  vrf_pkg::vreg_data_t vs1_data_i,
  input  vrf_pkg::vreg_data_t vs2_data_i,
  input  vrf_pkg::vreg_data_t vd_data_i,
  // Writeback
  output logic                we_o,
  output vrf_pkg::vreg_addr_t waddr_o,
  output vrf_pkg::vreg_data_t wdata_o,
  output logic                done_o
);

  vrf_pkg::vreg_data_t result;
  vrf_pkg::vreg_data_t result_q;
  vrf_pkg::vreg_addr_t vd_q;
  logic                valid_q;

  ////////////////////////////////////////
  // Stage 0
  ////////////////////////////////////////

  // Reads go out in the cycle the command arrives
  assign vs1_re_o   = valid_i;
  assign vs2_re_o   = valid_i;
  assign vd_re_o    = valid_i && (op_i == vrf_pkg::OP_ACC);
  assign vs1_addr_o = vs1_i;
  assign vs2_addr_o = vs2_i;
  assign vd_raddr_o = vd_i;

  always_comb begin : proc_compute
    logic [vrf_pkg::LaneWidth-1:0] a;
    logic [vrf_pkg::LaneWidth-1:0] b;
    logic [vrf_pkg::LaneWidth-1:0] d;
    result = '0;
    for (int l = 0; l < vrf_pkg::NrLanes; l++) begin
      a = vs1_data_i[l*vrf_pkg::LaneWidth +: vrf_pkg::LaneWidth];
      b = vs2_data_i[l*vrf_pkg::LaneWidth +: vrf_pkg::LaneWidth];
      d = vd_data_i[l*vrf_pkg::LaneWidth +: vrf_pkg::LaneWidth];
      // Lane sums wrap at the lane width
      unique case (op_i)
        vrf_pkg::OP_ADD: result[l*vrf_pkg::LaneWidth +: vrf_pkg::LaneWidth] = a + b;
        vrf_pkg::OP_SUB: result[l*vrf_pkg::LaneWidth +: vrf_pkg::LaneWidth] = a - b;
        vrf_pkg::OP_XOR: result[l*vrf_pkg::LaneWidth +: vrf_pkg::LaneWidth] = a ^ b;
        default:         result[l*vrf_pkg::LaneWidth +: vrf_pkg::LaneWidth] = d + a + b;
      endcase
    end
  end

  ////////////////////////////////////////
  // Stage 1
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_q <= result;
      vd_q     <= vd_i;
    end
  end

  // Writeback always wins its bank, so done follows the write enable
  assign we_o    = valid_q;
  assign waddr_o = vd_q;
  assign wdata_o = result_q;
  assign done_o  = valid_q;

endmodule

/* vrf.sv */
// Banked vector register file
// Fixed-priority mapping of five read and three write requesters onto two banks

module vrf (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  // Write requesters
  input  vrf_pkg::vreg_addr_t [vrf_pkg::NrWritePorts-1:0]     waddr_i,
  input  vrf_pkg::vreg_data_t [vrf_pkg::NrWritePorts-1:0]     wdata_i,
  input  logic                [vrf_pkg::NrWritePorts-1:0]     we_i,
  input  vrf_pkg::vreg_be_t   [vrf_pkg::NrWritePorts-1:0]     wbe_i,
  output logic                [vrf_pkg::NrWritePorts-1:0]     wvalid_o,
  // Read requesters
  input  vrf_pkg::vreg_addr_t [vrf_pkg::NrReadPorts-1:0]      raddr_i,
  input  logic                [vrf_pkg::NrReadPorts-1:0]      re_i,
  output vrf_pkg::vreg_data_t [vrf_pkg::NrReadPorts-1:0]      rdata_o,
  output logic                [vrf_pkg::NrReadPorts-1:0]      rvalid_o
);

  // Bank side write port
  vrf_pkg::bank_addr_t [vrf_pkg::NrBanks-1:0] bank_waddr;
  vrf_pkg::vreg_data_t [vrf_pkg::NrBanks-1:0] bank_wdata;
  logic                [vrf_pkg::NrBanks-1:0] bank_we;
  vrf_pkg::vreg_be_t   [vrf_pkg::NrBanks-1:0] bank_wbe;

  // Bank side read ports
  vrf_pkg::bank_addr_t [vrf_pkg::NrBanks-1:0][vrf_pkg::NrBankReadPorts-1:0] bank_raddr;
  vrf_pkg::vreg_data_t [vrf_pkg::NrBanks-1:0][vrf_pkg::NrBankReadPorts-1:0] bank_rdata;

  ////////////////////////////////////////
  // Write mapping
  ////////////////////////////////////////

  always_comb begin : proc_write
    logic taken;
    bank_waddr = '0;
    bank_wdata = '0;
    bank_we    = '0;
    bank_wbe   = '0;
    wvalid_o   = '0;
    for (int b = 0; b < vrf_pkg::NrBanks; b++) begin
      taken = 1'b0;
      // Lower requester index wins: VFU, then LSU, then slide
      for (int w = 0; w < vrf_pkg::NrWritePorts; w++) begin
        if (!taken && we_i[w] && waddr_i[w].bank == 1'(b)) begin
          taken         = 1'b1;
          bank_waddr[b] = waddr_i[w].row;
          bank_wdata[b] = wdata_i[w];
          bank_we[b]    = 1'b1;
          bank_wbe[b]   = wbe_i[w];
          wvalid_o[w]   = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read mapping
  ////////////////////////////////////////

  always_comb begin : proc_read
    bank_raddr = '0;
    rdata_o    = '0;
    rvalid_o   = '0;
    for (int b = 0; b < vrf_pkg::NrBanks; b++) begin
      // Port 0 serves VFU vs2 only
      if (re_i[vrf_pkg::VFU_VS2_RD] && raddr_i[vrf_pkg::VFU_VS2_RD].bank == 1'(b)) begin
        bank_raddr[b][0]                = raddr_i[vrf_pkg::VFU_VS2_RD].row;
        rdata_o[vrf_pkg::VFU_VS2_RD]    = bank_rdata[b][0];
        rvalid_o[vrf_pkg::VFU_VS2_RD]   = 1'b1;
      end

      // Port 1: VFU vs1, then slide
      if (re_i[vrf_pkg::VFU_VS1_RD] && raddr_i[vrf_pkg::VFU_VS1_RD].bank == 1'(b)) begin
        bank_raddr[b][1]                = raddr_i[vrf_pkg::VFU_VS1_RD].row;
        rdata_o[vrf_pkg::VFU_VS1_RD]    = bank_rdata[b][1];
        rvalid_o[vrf_pkg::VFU_VS1_RD]   = 1'b1;
      end else if (re_i[vrf_pkg::VSLDU_VS2_RD] &&
                   raddr_i[vrf_pkg::VSLDU_VS2_RD].bank == 1'(b)) begin
        bank_raddr[b][1]                = raddr_i[vrf_pkg::VSLDU_VS2_RD].row;
        rdata_o[vrf_pkg::VSLDU_VS2_RD]  = bank_rdata[b][1];
        rvalid_o[vrf_pkg::VSLDU_VS2_RD] = 1'b1;
      end

      // Port 2: VFU vd, then LSU
      if (re_i[vrf_pkg::VFU_VD_RD] && raddr_i[vrf_pkg::VFU_VD_RD].bank == 1'(b)) begin
        bank_raddr[b][2]                = raddr_i[vrf_pkg::VFU_VD_RD].row;
        rdata_o[vrf_pkg::VFU_VD_RD]     = bank_rdata[b][2];
        rvalid_o[vrf_pkg::VFU_VD_RD]    = 1'b1;
      end else if (re_i[vrf_pkg::VLSU_VD_RD] &&
                   raddr_i[vrf_pkg::VLSU_VD_RD].bank == 1'(b)) begin
        bank_raddr[b][2]                = raddr_i[vrf_pkg::VLSU_VD_RD].row;
        rdata_o[vrf_pkg::VLSU_VD_RD]    = bank_rdata[b][2];
        rvalid_o[vrf_pkg::VLSU_VD_RD]   = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Banks
  ////////////////////////////////////////

  for (genvar b = 0; b < vrf_pkg::NrBanks; b++) begin : gen_banks
    vrf_bank i_bank (
      .clk_i   (clk_i        ),
      .arst_n_i(arst_n_i     ),
      .waddr_i (bank_waddr[b]),
      .wdata_i (bank_wdata[b]),
      .we_i    (bank_we[b]   ),
      .wbe_i   (bank_wbe[b]  ),
      .raddr_i (bank_raddr[b]),
      .rdata_o (bank_rdata[b])
    );
  end

endmodule

/* vrf_bank.sv */
// Vector register bank
// Eight rows, one byte-masked write port and three asynchronous read ports

module vrf_bank (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  // Write port
  input  vrf_pkg::bank_addr_t                                waddr_i,
  input  vrf_pkg::vreg_data_t                                wdata_i,
  input  logic                                               we_i,
  input  vrf_pkg::vreg_be_t                                  wbe_i,
  // Read ports
  input  vrf_pkg::bank_addr_t [vrf_pkg::NrBankReadPorts-1:0] raddr_i,
  output vrf_pkg::vreg_data_t [vrf_pkg::NrBankReadPorts-1:0] rdata_o
);

  vrf_pkg::vreg_data_t mem_q [vrf_pkg::NrRows];

  ////////////////////////////////////////
  // Write
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < vrf_pkg::NrRows; r++) begin
        mem_q[r] <= '0;
      end
    end else if (we_i) begin
      // Only enabled bytes change
      for (int b = 0; b < vrf_pkg::NrBytes; b++) begin
        if (wbe_i[b]) begin
          mem_q[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Read
  ////////////////////////////////////////

  for (genvar p = 0; p < vrf_pkg::NrBankReadPorts; p++) begin : gen_rd
    assign rdata_o[p] = mem_q[raddr_i[p]];
  end

endmodule

/* vrf_pkg.sv */
// Vector register file package
// Widths, register address layout, requester port indices and VFU opcodes

package vrf_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int unsigned DataWidth       = 64;
  localparam int unsigned NrVregs         = 16;
  localparam int unsigned NrBanks         = 2;
  localparam int unsigned LaneWidth       = 32;
  localparam int unsigned NrLanes         = DataWidth / LaneWidth;
  localparam int unsigned NrBytes         = DataWidth / 8;
  localparam int unsigned NrRows          = NrVregs / NrBanks;
  localparam int unsigned RowWidth        = $clog2(NrRows);
  localparam int unsigned NrBankReadPorts = 3;
  localparam int unsigned NrReadPorts     = 5;
  localparam int unsigned NrWritePorts    = 3;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [RowWidth-1:0] bank_addr_t;

  // Bank select sits in the lowest bit of the register number
  typedef struct packed {
    bank_addr_t row;
    logic       bank;
  } vreg_addr_t;

  typedef logic [DataWidth-1:0] vreg_data_t;
  typedef logic [NrBytes-1:0]   vreg_be_t;

  // Write requesters, index order is also the priority order
  typedef enum int unsigned {
    VFU_VD_WD   = 0,
    VLSU_VD_WD  = 1,
    VSLDU_VD_WD = 2
  } wport_e;

  typedef enum int unsigned {
    VFU_VS2_RD   = 0,
    VFU_VS1_RD   = 1,
    VFU_VD_RD    = 2,
    VLSU_VD_RD   = 3,
    VSLDU_VS2_RD = 4
  } rport_e;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_XOR = 2'd2,
    OP_ACC = 2'd3
  } vfu_op_e;

endpackage
